// ==== src/pcs_pkg.sv ====
package pcs_pkg;

	// 64b/66b block geometry
	localparam int unsigned HEAD_W = 2;
	localparam int unsigned DATA_W = 64;
	localparam int unsigned BYTE_N = DATA_W / 8;
	localparam int unsigned CTRL_W = DATA_W - 8;

	// sync header codes, 00 and 11 are illegal
	localparam logic [HEAD_W-1:0] SYNC_DATA = 2'b01;
	localparam logic [HEAD_W-1:0] SYNC_CTRL = 2'b10;

	// block lock thresholds
	localparam int unsigned LOCK_CNT_N = 64;
	localparam int unsigned BAD_WIN_N = 64;
	localparam int unsigned BAD_MAX_N = 16;

	localparam int unsigned LOCK_CNT_W = $clog2(LOCK_CNT_N);
	localparam int unsigned BAD_WIN_W = $clog2(BAD_WIN_N);
	localparam int unsigned BAD_MAX_W = $clog2(BAD_MAX_N);

	// terminal counts, one below the thresholds
	localparam logic [LOCK_CNT_W-1:0] LOCK_CNT_LAST = LOCK_CNT_W'(LOCK_CNT_N - 1);
	localparam logic [BAD_WIN_W-1:0] BAD_WIN_LAST = BAD_WIN_W'(BAD_WIN_N - 1);
	localparam logic [BAD_MAX_W-1:0] BAD_MAX_LAST = BAD_MAX_W'(BAD_MAX_N - 1);

	// scrambler taps for x^58 + x^39 + 1
	localparam int unsigned SCR_TAP_A = 39;
	localparam int unsigned SCR_TAP_B = 58;

	// block type field of control blocks
	localparam logic [7:0] BT_IDLE = 8'h1e;
	localparam logic [7:0] BT_START0 = 8'h78;
	localparam logic [7:0] BT_START4 = 8'h33;
	localparam logic [7:0] BT_ORD = 8'h4b;
	localparam logic [7:0] BT_TERM0 = 8'h87;
	localparam logic [7:0] BT_TERM1 = 8'h99;
	localparam logic [7:0] BT_TERM2 = 8'haa;
	localparam logic [7:0] BT_TERM3 = 8'hb4;
	localparam logic [7:0] BT_TERM4 = 8'hcc;
	localparam logic [7:0] BT_TERM5 = 8'hd2;
	localparam logic [7:0] BT_TERM6 = 8'he1;
	localparam logic [7:0] BT_TERM7 = 8'hff;

	// type byte is sent first, so it sits in the low bits
	typedef struct packed {
		logic [CTRL_W-1:0] content;
		logic [7:0]        btype;
	} ctrl_view_s;

	// same payload seen as data bytes or as a control block
	typedef union packed {
		logic [BYTE_N-1:0][7:0] bytes;
		ctrl_view_s             ctrl;
	} block_payload_u;

	typedef struct packed {
		logic [HEAD_W-1:0] head;
		block_payload_u    payload;
	} pcs_block_s;

endpackage

// ==== src/mac_pkg.sv ====
package mac_pkg;

	// one keep bit per byte lane
	localparam int unsigned KEEP_W = 8;

	// start at lane 0 and start at lane 4
	localparam int unsigned START_N = 2;

	// data lanes carried by the two start blocks
	localparam logic [KEEP_W-1:0] KEEP_START0 = 8'h7f;
	localparam logic [KEEP_W-1:0] KEEP_START4 = 8'h70;

	// lite MAC word, data lane 0 in the low byte
	typedef struct packed {
		logic                    ctrl_v;
		logic                    idle_v;
		logic [START_N-1:0]      start_v;
		logic                    term_v;
		logic                    err_v;
		logic                    ord_v;
		logic [KEEP_W-1:0][7:0]  data;
		logic [KEEP_W-1:0]       keep;
	} mac_word_s;

endpackage

// ==== src/block_sync_rx.sv ====
`timescale 1ns/1ps

module block_sync_rx (
	input  logic                       clk,
	input  logic                       arst_n_i,
	input  logic                       valid_i,
	input  logic [pcs_pkg::HEAD_W-1:0] head_i,
	output logic                       slip_o,
	output logic                       lock_o
);

	logic head_bad;
	logic good_last;
	logic win_last;
	logic bad_last;

	// consecutive good headers while hunting
	logic [pcs_pkg::LOCK_CNT_W-1:0] good_cnt_q;

	// position in the current window and bad headers seen in it
	logic [pcs_pkg::BAD_WIN_W-1:0] win_cnt_q;
	logic [pcs_pkg::BAD_MAX_W-1:0] bad_cnt_q;

	assign head_bad = (head_i != pcs_pkg::SYNC_DATA) && (head_i != pcs_pkg::SYNC_CTRL);

	assign good_last = (good_cnt_q == pcs_pkg::LOCK_CNT_LAST);
	assign win_last = (win_cnt_q == pcs_pkg::BAD_WIN_LAST);
	assign bad_last = (bad_cnt_q == pcs_pkg::BAD_MAX_LAST);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			lock_o <= 1'b0;
			slip_o <= 1'b0;
			good_cnt_q <= '0;
			win_cnt_q <= '0;
			bad_cnt_q <= '0;
		end else begin
			// slip is a single cycle pulse
			slip_o <= 1'b0;
			if (valid_i) begin
				if (!lock_o) begin
					// hunting for 64 good headers in a row
					if (head_bad) begin
						good_cnt_q <= '0;
						slip_o <= 1'b1;
					end else if (good_last) begin
						good_cnt_q <= '0;
						lock_o <= 1'b1;
					end else begin
						good_cnt_q <= good_cnt_q + 1'b1;
					end
				end else if (head_bad && bad_last) begin
					// too many bad headers in this window
					lock_o <= 1'b0;
					slip_o <= 1'b1;
					win_cnt_q <= '0;
					bad_cnt_q <= '0;
				end else if (win_last) begin
					// window closed below the limit, start over
					win_cnt_q <= '0;
					bad_cnt_q <= '0;
				end else begin
					win_cnt_q <= win_cnt_q + 1'b1;
					if (head_bad) begin
						bad_cnt_q <= bad_cnt_q + 1'b1;
					end
				end
			end
		end
	end

endmodule

// ==== src/descrambler_rx.sv ====
`timescale 1ns/1ps

module descrambler_rx (
	input  logic                       clk,
	input  logic                       arst_n_i,
	input  logic                       valid_i,
	input  logic [pcs_pkg::HEAD_W-1:0] head_i,
	input  logic [pcs_pkg::DATA_W-1:0] data_i,
	output logic                       blk_v_o,
	output pcs_pkg::pcs_block_s        blk_o
);

	// last 58 scrambled bits, bit 0 oldest
	logic [pcs_pkg::SCR_TAP_B-1:0] hist_q;

	// history followed by the new block, in arrival order
	logic [pcs_pkg::SCR_TAP_B+pcs_pkg::DATA_W-1:0] stream;
	logic [pcs_pkg::DATA_W-1:0] plain;

	assign stream = {data_i, hist_q};

	// out[i] = in[i] ^ in[i-39] ^ in[i-58]
	assign plain = data_i
		^ stream[pcs_pkg::SCR_TAP_B-pcs_pkg::SCR_TAP_A +: pcs_pkg::DATA_W]
		^ stream[0 +: pcs_pkg::DATA_W];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			blk_v_o <= 1'b0;
		end else begin
			blk_v_o <= valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_i) begin
			hist_q <= stream[pcs_pkg::DATA_W +: pcs_pkg::SCR_TAP_B];
			blk_o.head <= head_i;
			blk_o.payload.bytes <= plain;
		end
	end

endmodule

// ==== src/dec_lite_rx.sv ====
`timescale 1ns/1ps

module dec_lite_rx (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                lock_i,
	input  logic                blk_v_i,
	input  pcs_pkg::pcs_block_s blk_i,
	output logic                valid_o,
	output mac_pkg::mac_word_s  mac_o
);

	logic [7:0] btype;
	logic       term_hit;

	// number of data bytes ahead of the terminate
	logic [$clog2(mac_pkg::KEEP_W)-1:0] term_n;
	logic [mac_pkg::KEEP_W-1:0]         term_keep;

	mac_pkg::mac_word_s dec;

	assign btype = blk_i.payload.ctrl.btype;

	always_comb begin
		term_hit = 1'b1;
		term_n = '0;
		case (btype)
			pcs_pkg::BT_TERM0: term_n = 3'd0;
			pcs_pkg::BT_TERM1: term_n = 3'd1;
			pcs_pkg::BT_TERM2: term_n = 3'd2;
			pcs_pkg::BT_TERM3: term_n = 3'd3;
			pcs_pkg::BT_TERM4: term_n = 3'd4;
			pcs_pkg::BT_TERM5: term_n = 3'd5;
			pcs_pkg::BT_TERM6: term_n = 3'd6;
			pcs_pkg::BT_TERM7: term_n = 3'd7;
			default: term_hit = 1'b0;
		endcase
	end

	// low term_n lanes hold data
	always_comb begin
		for (int k = 0; k < mac_pkg::KEEP_W; k++) begin
			term_keep[k] = (k < int'(term_n));
		end
	end

	always_comb begin
		dec = '0;
		case (blk_i.head)
			pcs_pkg::SYNC_DATA: begin
				dec.data = blk_i.payload.bytes;
				dec.keep = '1;
			end
			pcs_pkg::SYNC_CTRL: begin
				dec.ctrl_v = 1'b1;
				// drop the type byte so lane 1 lands in data byte 0
				dec.data = {8'h00, blk_i.payload.ctrl.content};
				if (term_hit) begin
					dec.term_v = 1'b1;
					dec.keep = term_keep;
				end else begin
					case (btype)
						pcs_pkg::BT_IDLE: dec.idle_v = 1'b1;
						pcs_pkg::BT_ORD: dec.ord_v = 1'b1;
						pcs_pkg::BT_START0: begin
							dec.start_v[0] = 1'b1;
							dec.keep = mac_pkg::KEEP_START0;
						end
						pcs_pkg::BT_START4: begin
							dec.start_v[1] = 1'b1;
							dec.keep = mac_pkg::KEEP_START4;
						end
						default: dec.err_v = 1'b1;
					endcase
				end
			end
			// 00 or 11 header
			default: dec.err_v = 1'b1;
		endcase
	end

	// result stage
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_o <= 1'b0;
			mac_o <= '0;
		end else begin
			// blocks seen while unlocked are discarded
			valid_o <= blk_v_i & lock_i;
			if (blk_v_i) begin
				mac_o <= dec;
			end
		end
	end

endmodule

// ==== src/pcs_rx.sv ====
`timescale 1ns/1ps

module pcs_rx (
	input  logic                       clk,
	input  logic                       arst_n_i,

	// SerDes gearbox, data still scrambled
	input  logic                       serdes_v_i,
	input  logic [pcs_pkg::HEAD_W-1:0] serdes_head_i,
	input  logic [pcs_pkg::DATA_W-1:0] serdes_data_i,
	output logic                       gearbox_slip_o,

	// lite MAC
	output logic                       valid_o,
	output mac_pkg::mac_word_s         mac_o
);

	logic                lock;
	logic                blk_v;
	pcs_pkg::pcs_block_s blk;

	// block lock from sync headers
	block_sync_rx m_block_sync_rx (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.valid_i  (serdes_v_i),
		.head_i   (serdes_head_i),
		.slip_o   (gearbox_slip_o),
		.lock_o   (lock)
	);

	// runs on every block, locked or not, to stay in step
	descrambler_rx m_descrambler_rx (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.valid_i  (serdes_v_i),
		.head_i   (serdes_head_i),
		.data_i   (serdes_data_i),
		.blk_v_o  (blk_v),
		.blk_o    (blk)
	);

	dec_lite_rx m_dec_lite_rx (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.lock_i   (lock),
		.blk_v_i  (blk_v),
		.blk_i    (blk),
		.valid_o  (valid_o),
		.mac_o    (mac_o)
	);

endmodule

// ==== tb/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
	output logic clk_o
);

	// 100 ns period, 50 ns each phase
	initial begin
		clk_o = 1'b0;
		forever begin
			#50;
			clk_o = ~clk_o;
		end
	end

endmodule

// ==== tb/pcs_rx_assertions.sv ====
`timescale 1ns/1ps

module pcs_rx_assertions (
	input logic               clk,
	input logic               arst_n_i,
	input logic               serdes_v_i,
	input logic               lock_i,
	input logic               slip_i,
	input logic               valid_i,
	input mac_pkg::mac_word_s mac_i
);

	// slip only while hunting, or together with the unlock
	slip_while_locked: assert property (@(posedge clk) disable iff (!arst_n_i)
		!(slip_i && lock_i))
		else $error("gearbox slip requested while block lock is held");

	// valid_o two cycles after a block arrived, and only with lock
	valid_while_unlocked: assert property (@(posedge clk) disable iff (!arst_n_i)
		valid_i |-> $past(serdes_v_i, 2) && $past(lock_i))
		else $error("valid_o without a block accepted under block lock");

	// a block is one kind of frame control at most
	frame_flags_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
		valid_i |-> $onehot0({mac_i.idle_v, mac_i.start_v, mac_i.term_v, mac_i.ord_v}))
		else $error("more than one of idle, start, term and ord set");

endmodule

bind pcs_rx pcs_rx_assertions pcs_rx_assertions_inst (
	.clk        (clk),
	.arst_n_i   (arst_n_i),
	.serdes_v_i (serdes_v_i),
	.lock_i     (lock),
	.slip_i     (gearbox_slip_o),
	.valid_i    (valid_o),
	.mac_i      (mac_o)
);

// ==== tb/pcs_rx_tb.sv ====
`timescale 1ns/1ps

module pcs_rx_tb;

	// one table row, flags are {ctrl idle start[1:0] term err ord}
	typedef struct packed {
		logic [1:0] head;
		logic       is_data;
		logic [7:0] btype;
		logic [6:0] flags;
		logic [7:0] keep;
	} entry_s;

	logic                       clk;
	logic                       arst_n_i;
	logic                       serdes_v_i;
	logic [pcs_pkg::HEAD_W-1:0] serdes_head_i;
	logic [pcs_pkg::DATA_W-1:0] serdes_data_i;
	logic                       gearbox_slip_o;
	logic                       valid_o;
	mac_pkg::mac_word_s         mac_o;

	entry_s      tbl[$];
	logic [7:0]  term_types [8];
	logic [31:0] lfsr_q;
	logic [57:0] scr_hist;

	string test_name;
	int    test_errs;
	int    test_cnt;
	int    fail_cnt;
	int    err_total;

	clk_gen clk_gen_inst (.clk_o(clk));

	pcs_rx pcs_rx_inst (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.serdes_v_i     (serdes_v_i),
		.serdes_head_i  (serdes_head_i),
		.serdes_data_i  (serdes_data_i),
		.gearbox_slip_o (gearbox_slip_o),
		.valid_o        (valid_o),
		.mac_o          (mac_o)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
		lfsr_q = {lfsr_q[30:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] random_word();
		logic [63:0] w;
		for (int i = 0; i < 64; i++) begin
			w[i] = lfsr_bit();
		end
		return w;
	endfunction

	// s[n] = p[n] ^ s[n-39] ^ s[n-58], oldest bit at index 0
	function automatic logic [63:0] scramble(input logic [63:0] plain);
		logic [121:0] st;
		st = {64'h0, scr_hist};
		for (int i = 0; i < 64; i++) begin
			st[58 + i] = plain[i] ^ st[19 + i] ^ st[i];
		end
		scr_hist = st[121:64];
		return st[121:58];
	endfunction

	// one byte of ones per kept lane
	function automatic logic [63:0] lane_mask(input logic [7:0] keep);
		logic [63:0] m;
		for (int b = 0; b < 8; b++) begin
			m[8*b +: 8] = {8{keep[b]}};
		end
		return m;
	endfunction

	task automatic step();
		@(posedge clk);
		#10;
	endtask

	task automatic drive(input logic [1:0] head, input logic [63:0] plain);
		serdes_v_i = 1'b1;
		serdes_head_i = head;
		serdes_data_i = scramble(plain);
	endtask

	// one block, then wait for valid_o; lat is 0 when none came
	task automatic send_block(input logic [1:0] head, input logic [63:0] plain, output int lat);
		drive(head, plain);
		step();
		serdes_v_i = 1'b0;
		lat = 1;
		while (!valid_o && lat < 4) begin
			step();
			lat++;
		end
		if (!valid_o) begin
			lat = 0;
		end
	endtask

	task automatic check(input string sig, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH time=%0t signal=%s got=%0h expected=%0h", $time, sig, got, exp);
			test_errs++;
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		assert (cond) else begin
			$display("ERROR time=%0t %s", $time, what);
			test_errs++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic report_test();
		test_cnt++;
		err_total += test_errs;
		if (test_errs != 0) begin
			fail_cnt++;
		end
		$display("test %0d %s: %s", test_cnt, test_name, (test_errs == 0) ? "ok" : "FAILED");
	endtask

	initial begin
		int limit_ns;
		#1;
		limit_ns = (tbl.size() + pcs_pkg::LOCK_CNT_N + 200) * 100;
		#(limit_ns - 1);
		$display("ERROR watchdog expired after %0d ns, the test did not finish", limit_ns);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		entry_s      e;
		logic [63:0] payload;
		int          lat;
		int          bad_n;

		arst_n_i = 1'b0;
		serdes_v_i = 1'b0;
		serdes_head_i = '0;
		serdes_data_i = '0;
		lfsr_q = 32'h630c;
		scr_hist = '0;
		test_cnt = 0;
		fail_cnt = 0;
		err_total = 0;

		term_types = '{pcs_pkg::BT_TERM0, pcs_pkg::BT_TERM1, pcs_pkg::BT_TERM2,
			pcs_pkg::BT_TERM3, pcs_pkg::BT_TERM4, pcs_pkg::BT_TERM5,
			pcs_pkg::BT_TERM6, pcs_pkg::BT_TERM7};

		// head, data flag, type, flags, keep
		tbl.push_back({pcs_pkg::SYNC_DATA, 1'b1, 8'h00, 7'b0000000, 8'hff});
		tbl.push_back({pcs_pkg::SYNC_CTRL, 1'b0, pcs_pkg::BT_IDLE, 7'b1100000, 8'h00});
		tbl.push_back({pcs_pkg::SYNC_CTRL, 1'b0, pcs_pkg::BT_START0, 7'b1001000, 8'h7f});
		tbl.push_back({pcs_pkg::SYNC_CTRL, 1'b0, pcs_pkg::BT_START4, 7'b1010000, 8'h70});
		tbl.push_back({pcs_pkg::SYNC_CTRL, 1'b0, pcs_pkg::BT_ORD, 7'b1000001, 8'h00});
		// terminate n keeps the n low data bytes
		for (int n = 0; n < 8; n++) begin
			tbl.push_back({pcs_pkg::SYNC_CTRL, 1'b0, term_types[n], 7'b1000100, 8'((1 << n) - 1)});
		end
		tbl.push_back({pcs_pkg::SYNC_CTRL, 1'b0, 8'h00, 7'b1000010, 8'h00});
		tbl.push_back({pcs_pkg::SYNC_DATA, 1'b1, 8'h00, 7'b0000000, 8'hff});
		tbl.push_back({2'b00, 1'b0, pcs_pkg::BT_IDLE, 7'b0000010, 8'h00});
		tbl.push_back({2'b11, 1'b0, pcs_pkg::BT_IDLE, 7'b0000010, 8'h00});

		repeat (8) @(posedge clk);
		#10;
		arst_n_i = 1'b1;

		start_test("slip on invalid headers after reset");
		for (int i = 0; i < 4; i++) begin
			drive(i[0] ? 2'b11 : 2'b00, random_word());
			step();
			check("gearbox_slip_o", gearbox_slip_o, 1);
			serdes_v_i = 1'b0;
			step();
			check("gearbox_slip_o", gearbox_slip_o, 0);
			check("valid_o", valid_o, 0);
		end
		report_test();

		start_test("block lock after 64 good headers");
		for (int i = 0; i < pcs_pkg::LOCK_CNT_N; i++) begin
			payload = random_word();
			payload[7:0] = pcs_pkg::BT_IDLE;
			drive(pcs_pkg::SYNC_CTRL, payload);
			step();
			check("valid_o", valid_o, 0);
			check("gearbox_slip_o", gearbox_slip_o, 0);
		end
		serdes_v_i = 1'b0;
		step();
		check("valid_o", valid_o, 1);
		check("mac_o.idle_v", mac_o.idle_v, 1);
		report_test();

		foreach (tbl[t]) begin
			e = tbl[t];
			start_test($sformatf("table row %0d header %b type %02h", t, e.head, e.btype));
			payload = random_word();
			if (!e.is_data) begin
				payload[7:0] = e.btype;
			end
			send_block(e.head, payload, lat);
			expect_true(lat != 0, "no valid_o within 4 cycles of the block");
			if (lat != 0) begin
				check("valid_o latency", lat, 2);
				check("mac_o flags", {mac_o.ctrl_v, mac_o.idle_v, mac_o.start_v,
					mac_o.term_v, mac_o.err_v, mac_o.ord_v}, e.flags);
				check("mac_o.keep", mac_o.keep, e.keep);
				if (e.is_data) begin
					check("mac_o.data", mac_o.data, payload);
				end else if (e.keep != 8'h00) begin
					// control block data lanes follow the type byte
					check("mac_o.data", mac_o.data & lane_mask(e.keep),
						(payload >> 8) & lane_mask(e.keep));
				end
			end
			report_test();
		end

		start_test("lock loss after 16 invalid headers");
		// invalid headers since lock, all still in the first window
		bad_n = 0;
		foreach (tbl[t]) begin
			if (tbl[t].head != pcs_pkg::SYNC_DATA && tbl[t].head != pcs_pkg::SYNC_CTRL) begin
				bad_n++;
			end
		end
		for (int i = 0; i < 16; i++) begin
			drive(i[0] ? 2'b11 : 2'b00, random_word());
			step();
			bad_n++;
			// lock drops on the 16th, then each one slips while hunting
			check("gearbox_slip_o", gearbox_slip_o, bad_n >= pcs_pkg::BAD_MAX_N);
		end
		serdes_v_i = 1'b0;
		step();
		send_block(pcs_pkg::SYNC_DATA, random_word(), lat);
		expect_true(lat == 0, "valid_o still high after the lock was lost");
		drive(2'b00, random_word());
		step();
		check("gearbox_slip_o", gearbox_slip_o, 1);
		serdes_v_i = 1'b0;
		step();
		report_test();

		$display("tests %0d, failed %0d, check errors %0d", test_cnt, fail_cnt, err_total);
		if (fail_cnt == 0 && err_total == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== pcs_rx.f ====
src/pcs_pkg.sv
src/mac_pkg.sv
src/block_sync_rx.sv
src/descrambler_rx.sv
src/dec_lite_rx.sv
src/pcs_rx.sv
tb/clk_gen.sv
tb/pcs_rx_assertions.sv
tb/pcs_rx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the pcs_rx testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module pcs_rx_tb -f pcs_rx.f \
	|| { echo "compile failed"; exit 1; }

./obj_dir/Vpcs_rx_tb > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

grep -q -F '** FAIL **' sim.log && { echo "simulation failed"; exit 1; }
grep -q -F '** PASS **' sim.log || { echo "no pass result in sim.log"; exit 1; }
echo "simulation passed"
